// File: icache_ctrl.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_ctrl
	import icache_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     req_valid,
	input  cpu_req_t req,
	output logic     req_ready,
	input  logic     hit,
	input  way_t     hit_way,
	input  way_t     victim_way,
	input  logic     fill_valid,
	output index_t   index,
	output tag_t     tag,
	output offset_t  offset,
	output logic     rd_en,
	output way_t     rd_way,
	output logic     fill_en,
	output way_t     fill_way,
	output logic     touch_en,
	output way_t     touch_way,
	output logic     mem_req,
	output addr_t    mem_addr,
	output logic     resp_valid,
	output logic     resp_hit
);

	ctrl_state_e state, next_state;
	addr_t addr_q;
	way_t victim_q;
	logic lookup_hit;
	logic fill_take;

	// Address fields of the held request
	assign tag = addr_q[31 -: `ICACHE_TAG_W];
	assign index = addr_q[`ICACHE_BYTE_W + `ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	assign offset = addr_q[`ICACHE_BYTE_W +: `ICACHE_OFFSET_W];
	assign mem_addr = {tag, index, {(`ICACHE_OFFSET_W + `ICACHE_BYTE_W){1'b0}}};

	always_comb begin
		next_state = state;
		case (state)
			IDLE:      if (req_valid) next_state = LOOKUP;
			LOOKUP:    next_state = hit ? RESPOND : MISS_WAIT;
			MISS_WAIT: if (fill_valid) next_state = RESPOND;
			RESPOND:   next_state = IDLE;
			default:   next_state = IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state <= IDLE;
			resp_hit <= 1'b0;
		end else begin
			state <= next_state;
			if (state == LOOKUP) resp_hit <= hit;
		end
	end

	// Request address and the victim picked at lookup time
	always_ff @(posedge CLK) begin
		if (req_valid && req_ready) addr_q <= req.addr;
		if (state == LOOKUP && !hit) victim_q <= victim_way;
	end

	// Read and LRU touch happen once, on the hit or on the fill
	assign lookup_hit = (state == LOOKUP) && hit;
	assign fill_take = (state == MISS_WAIT) && fill_valid;
	assign rd_en = lookup_hit || fill_take;
	assign rd_way = fill_take ? victim_q : hit_way;
	assign fill_en = fill_take;
	assign fill_way = victim_q;
	assign touch_en = rd_en;
	assign touch_way = rd_way;

	assign req_ready = (state == IDLE);
	assign mem_req = (state == MISS_WAIT);
	assign resp_valid = (state == RESPOND);

endmodule

// File: icache_data_array.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_data_array
	import icache_pkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  index_t  index,
	input  offset_t offset,
	input  logic    rd_en,
	input  way_t    rd_way,
	input  logic    fill_en,
	input  way_t    fill_way,
	input  fill_t   fill,
	output word_t   word
);

	line_t lines [`ICACHE_SETS][`ICACHE_WAYS];
	word_t [`ICACHE_LINE_WORDS-1:0] src_words;

	// On a fill the incoming line is read directly, the array write lands the same edge
	assign src_words = fill_en ? fill.line : lines[index][rd_way];

	always_ff @(posedge CLK) begin
		if (fill_en) begin
			lines[index][fill_way] <= fill.line;
		end
	end

	// Registered word select
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			word <= '0;
		end else if (rd_en) begin
			word <= src_words[offset];
		end
	end

endmodule

// File: icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Cache organization
`define ICACHE_WAYS 4
`define ICACHE_SETS 128
`define ICACHE_LINE_WORDS 8

// Address split, byte address bits [1:0] are ignored
// Tag [31:12], index [11:5], word offset [4:2]
`define ICACHE_TAG_W 20
`define ICACHE_INDEX_W 7
`define ICACHE_OFFSET_W 3

// Byte bits below the word offset
`define ICACHE_BYTE_W 2

`endif

// File: icache_lru.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_lru
	import icache_pkg::*;
(
	input  logic                         CLK,
	input  logic                         RST,
	input  index_t                       index,
	input  logic                         touch_en,
	input  way_t                         touch_way,
	output rank_t [`ICACHE_WAYS-1:0]     ranks
);

	localparam rank_t RANK_MRU = rank_t'(`ICACHE_WAYS - 1);

	rank_t [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] rank_q;
	rank_t [`ICACHE_WAYS-1:0] set_ranks;
	rank_t touched_rank;

	assign set_ranks = rank_q[index];
	assign touched_rank = set_ranks[touch_way];

	// Ranks of the looked-up set feed the victim choice
	assign ranks = set_ranks;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			// Way 0 starts as least recent, way 3 as most recent
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					rank_q[s][w] <= rank_t'(w);
				end
			end
		end else if (touch_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (way_t'(w) == touch_way) begin
					rank_q[index][w] <= RANK_MRU;
				end else if (set_ranks[w] > touched_rank) begin
					// Ways more recent than the touched one slide down by one
					rank_q[index][w] <= set_ranks[w] - 1'b1;
				end
			end
		end
	end

endmodule

// File: icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;
	typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

	// Word 0 sits in the low 32 bits
	typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

	typedef logic [1:0] way_t;

	// 3 is most recent, 0 is the next victim
	typedef logic [1:0] rank_t;

	typedef struct packed {
		addr_t addr;
	} cpu_req_t;

	typedef struct packed {
		word_t data;
		logic  hit;
	} cpu_resp_t;

	typedef struct packed {
		line_t line;
	} fill_t;

	typedef enum logic [1:0] {IDLE, LOOKUP, MISS_WAIT, RESPOND} ctrl_state_e;

endpackage

// File: icache_props.sv
`timescale 1ns/1ns

module icache_props (
	input logic CLK,
	input logic RST,
	input logic req_valid,
	input logic req_ready,
	input logic resp_valid,
	input logic mem_req,
	input logic fill_valid
);

	logic busy;

	// Outstanding request, from acceptance up to the response
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			busy <= 1'b0;
		end else if (req_valid && req_ready) begin
			busy <= 1'b1;
		end else if (resp_valid) begin
			busy <= 1'b0;
		end
	end

	mem_req_hold: assert property (@(posedge CLK) disable iff (!RST)
		mem_req && !fill_valid |=> mem_req)
		else $error("mem_req dropped before fill_valid");

	resp_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
		resp_valid |=> !resp_valid)
		else $error("resp_valid held longer than one cycle");

	ready_low_busy: assert property (@(posedge CLK) disable iff (!RST)
		busy |-> !req_ready)
		else $error("req_ready high while a request is outstanding");

endmodule

// File: icache_tag_array.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_tag_array
	import icache_pkg::*;
(
	input  logic                         CLK,
	input  logic                         RST,
	input  index_t                       index,
	input  tag_t                         tag,
	input  rank_t [`ICACHE_WAYS-1:0]     ranks,
	input  logic                         fill_en,
	input  way_t                         fill_way,
	output logic                         hit,
	output way_t                         hit_way,
	output way_t                         victim_way
);

	logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid;
	tag_t tags [`ICACHE_SETS][`ICACHE_WAYS];

	// Valid bits come up clear
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[index][fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_en) begin
			tags[index][fill_way] <= tag;
		end
	end

	// Tag compare over all ways of the set
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (!hit && valid[index][w] && tags[index][w] == tag) begin
				hit = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// Lowest invalid way first and the rank 0 way otherwise
	always_comb begin
		logic inv_found;
		inv_found = 1'b0;
		victim_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (!inv_found && !valid[index][w]) begin
				inv_found = 1'b1;
				victim_way = way_t'(w);
			end
		end
		if (!inv_found) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (ranks[w] == '0) begin
					victim_way = way_t'(w);
				end
			end
		end
	end

endmodule

// File: icache_tb.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_tb
	import icache_pkg::*;
;

	localparam int N_RANDOM = 64;
	localparam int TOTAL_REQ = 27 + N_RANDOM;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_REQ + 10;
	localparam word_t LINE_XOR = 32'h5A3C_96E1;
	localparam tag_t RAND_TAG_BASE = 20'h0C0D0;

	logic CLK;
	logic RST;
	logic req_valid;
	cpu_req_t req;
	logic req_ready;
	logic resp_valid;
	cpu_resp_t resp;
	logic mem_req;
	addr_t mem_addr;
	logic fill_valid;
	fill_t fill;

	// Reference cache state
	logic ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
	tag_t ref_tag [`ICACHE_SETS][`ICACHE_WAYS];
	rank_t ref_rank [`ICACHE_SETS][`ICACHE_WAYS];

	logic exp_hit_q [$];
	word_t exp_data_q [$];
	logic [15:0] lfsr_q = 16'd4;
	addr_t cur_addr;
	int cycle_cnt = 0;
	int accept_cycle = 0;
	int fill_cycle = 0;
	int mem_cnt = 0;
	int resp_cnt = 0;
	int ref_misses = 0;
	logic exp_h;
	word_t exp_d;

	tb_clock_gen u_clock_gen (.CLK(CLK), .RST(RST));

	icache_top DUT (
		.CLK, .RST, .req_valid, .req, .req_ready, .resp_valid, .resp,
		.mem_req, .mem_addr, .fill_valid, .fill
	);

	bind icache_top icache_props u_props (
		.CLK(CLK), .RST(RST), .req_valid(req_valid), .req_ready(req_ready),
		.resp_valid(resp_valid), .mem_req(mem_req), .fill_valid(fill_valid)
	);

	task automatic stop_fail(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			stop_fail($sformatf("Mismatch at %0t ns: %s is %08h, expected %08h",
				$time, what, got, exp));
	endtask

	task automatic check_hit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_fail($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			stop_fail($sformatf("Mismatch at %0t ns: %s is %08h, expected %08h",
				$time, what, got, exp));
	endtask

	task automatic check_int(input int got, input int exp, input string what);
		if (got != exp)
			stop_fail($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = (v << 1) | lfsr_q[0];
		end
		return v;
	endfunction

	// Word number goes in the low bits of the line address
	function automatic word_t mem_word(input addr_t a, input offset_t w);
		return ({a[31:5], 5'b0} | 32'(w)) ^ LINE_XOR;
	endfunction

	function automatic fill_t make_fill(input addr_t a);
		fill_t f;
		for (int w = 0; w < `ICACHE_LINE_WORDS; w++)
			f.line[w*32 +: 32] = mem_word(a, offset_t'(w));
		return f;
	endfunction

	function automatic addr_t make_addr(input tag_t t, input index_t s, input offset_t o,
		input logic [1:0] b);
		return {t, s, o, b};
	endfunction

	// Returns the hit flag and sets data to the word the cache must answer with
	function automatic logic ref_access(input addr_t a, output word_t data);
		tag_t t;
		index_t s;
		int way;
		logic hit;
		rank_t old_rank;
		t = a[31:12];
		s = a[11:5];
		hit = 1'b0;
		way = -1;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (ref_valid[s][w] && ref_tag[s][w] == t) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
				if (!ref_valid[s][w]) way = w;
			if (way < 0) begin
				for (int w = 0; w < `ICACHE_WAYS; w++)
					if (ref_rank[s][w] == 2'd0) way = w;
			end
			ref_valid[s][way] = 1'b1;
			ref_tag[s][way] = t;
		end
		old_rank = ref_rank[s][way];
		for (int w = 0; w < `ICACHE_WAYS; w++)
			if (ref_rank[s][w] > old_rank) ref_rank[s][w] = ref_rank[s][w] - 2'd1;
		ref_rank[s][way] = 2'd3;
		data = mem_word(a, a[4:2]);
		return hit;
	endfunction

	task automatic ref_reset();
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w] = '0;
				ref_rank[s][w] = rank_t'(w);
			end
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic issue(input addr_t a);
		word_t d;
		logic h;
		while (!req_ready) begin
			@(posedge CLK);
			#1;
		end
		h = ref_access(a, d);
		if (!h) ref_misses++;
		exp_hit_q.push_back(h);
		exp_data_q.push_back(d);
		cur_addr = a;
		req.addr = a;
		req_valid = 1'b1;
		@(posedge CLK);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_hit_q.size() != 0) @(negedge CLK);
		check_int(mem_cnt, ref_misses, "memory request count");
		@(posedge CLK);
		#1;
	endtask

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES)
			stop_fail("Timeout: the run did not finish within the cycle limit");
	end

	// Compare process sampling at the falling edge
	always @(negedge CLK) begin
		if (RST) begin
			if (req_valid && req_ready) accept_cycle = cycle_cnt;
			if (mem_req && fill_valid) fill_cycle = cycle_cnt;
			if (resp_valid) begin
				if (exp_hit_q.size() == 0)
					stop_fail("A response arrived with no request outstanding");
				exp_h = exp_hit_q.pop_front();
				exp_d = exp_data_q.pop_front();
				check_hit(resp.hit, exp_h, "hit flag");
				check_word(resp.data, exp_d, "data word");
				if (exp_h)
					check_int(cycle_cnt - accept_cycle, 2, "hit latency");
				else
					check_int(cycle_cnt - fill_cycle, 1, "fill to response latency");
				resp_cnt++;
			end
		end
	end

	// Memory model with 1 to 8 cycles of fill latency
	initial begin : memory_model
		int unsigned delay;
		fill_valid = 1'b0;
		fill = '0;
		forever begin
			@(negedge CLK);
			if (RST && mem_req) begin
				mem_cnt++;
				check_addr(mem_addr, {cur_addr[31:5], 5'b0}, "mem_addr");
				delay = 1 + take_bits(3);
				repeat (delay) @(posedge CLK);
				#1;
				fill_valid = 1'b1;
				fill = make_fill(mem_addr);
				@(posedge CLK);
				#1;
				fill_valid = 1'b0;
			end
		end
	end

	initial begin : stimulus
		tag_t t;
		index_t s;
		offset_t o;
		logic [1:0] b;
		req_valid = 1'b0;
		req = '0;
		cur_addr = '0;
		ref_reset();
		@(posedge RST);
		@(negedge CLK);
		check_hit(req_ready, 1'b1, "req_ready after reset");
		check_hit(mem_req, 1'b0, "mem_req after reset");
		check_hit(resp_valid, 1'b0, "resp_valid after reset");
		@(posedge CLK);
		#1;

		// First access misses and the rest of the line hits
		issue(make_addr(20'h12345, 7'd5, 3'd3, 2'd0));
		drain();
		for (int i = 0; i < `ICACHE_LINE_WORDS; i++)
			issue(make_addr(20'h12345, 7'd5, offset_t'(i), 2'd0));
		drain();

		// Fill all four ways of set 9 and then hit each
		for (int i = 0; i < 8; i++)
			issue(make_addr(20'h00A00 + tag_t'(i % 4), 7'd9, offset_t'(i), 2'd0));
		drain();

		// Touch order 2 0 3 1 leaves tag 2 least recent
		issue(make_addr(20'h00A02, 7'd9, 3'd1, 2'd0));
		issue(make_addr(20'h00A00, 7'd9, 3'd2, 2'd0));
		issue(make_addr(20'h00A03, 7'd9, 3'd3, 2'd0));
		issue(make_addr(20'h00A01, 7'd9, 3'd4, 2'd0));
		issue(make_addr(20'h00A04, 7'd9, 3'd5, 2'd0));
		issue(make_addr(20'h00A00, 7'd9, 3'd6, 2'd0));
		issue(make_addr(20'h00A03, 7'd9, 3'd7, 2'd0));
		issue(make_addr(20'h00A01, 7'd9, 3'd0, 2'd0));
		issue(make_addr(20'h00A04, 7'd9, 3'd1, 2'd0));
		issue(make_addr(20'h00A02, 7'd9, 3'd2, 2'd0));
		drain();

		// Random traffic over two sets and eight tags
		for (int i = 0; i < N_RANDOM; i++) begin
			t = RAND_TAG_BASE + tag_t'(take_bits(3));
			s = index_t'(20 + take_bits(1));
			o = offset_t'(take_bits(3));
			b = 2'(take_bits(2));
			issue(make_addr(t, s, o, b));
		end
		drain();
		check_int(resp_cnt, TOTAL_REQ, "response count");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: icache_top.sv
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_top
	import icache_pkg::*;
(
	input  logic      CLK,
	input  logic      RST,
	input  logic      req_valid,
	input  cpu_req_t  req,
	output logic      req_ready,
	output logic      resp_valid,
	output cpu_resp_t resp,
	output logic      mem_req,
	output addr_t     mem_addr,
	input  logic      fill_valid,
	input  fill_t     fill
);

	index_t index;
	tag_t tag;
	offset_t offset;
	logic hit;
	way_t hit_way;
	way_t victim_way;
	logic rd_en;
	way_t rd_way;
	logic fill_en;
	way_t fill_way;
	logic touch_en;
	way_t touch_way;
	rank_t [`ICACHE_WAYS-1:0] ranks;
	word_t word;
	logic resp_hit;

	icache_ctrl u_ctrl (
		.CLK, .RST, .req_valid, .req, .req_ready,
		.hit, .hit_way, .victim_way, .fill_valid,
		.index, .tag, .offset,
		.rd_en, .rd_way, .fill_en, .fill_way, .touch_en, .touch_way,
		.mem_req, .mem_addr, .resp_valid, .resp_hit
	);

	icache_tag_array u_tag_array (
		.CLK, .RST, .index, .tag, .ranks,
		.fill_en, .fill_way, .hit, .hit_way, .victim_way
	);

	icache_lru u_lru (
		.CLK, .RST, .index, .touch_en, .touch_way, .ranks
	);

	icache_data_array u_data_array (
		.CLK, .RST, .index, .offset, .rd_en, .rd_way,
		.fill_en, .fill_way, .fill, .word
	);

	// Response word and hit flag travel together
	assign resp.data = word;
	assign resp.hit = resp_hit;

endmodule

// File: list.f
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_lru.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
icache_props.sv
icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
exit 1

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int HALF_PERIOD = 50,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// Release just after a rising edge
	initial begin
		RST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		RST = 1'b1;
	end

endmodule
